// File: logic/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    localparam logic [6:0] op_lui   = 7'b0110111; // U format
    localparam logic [6:0] op_auipc = 7'b0010111; // U format
    localparam logic [6:0] op_jal   = 7'b1101111; // J format
    localparam logic [6:0] op_jalr  = 7'b1100111; // I format
    localparam logic [6:0] op_br    = 7'b1100011; // B format
    localparam logic [6:0] op_imm   = 7'b0010011; // I format arithmetic
    localparam logic [6:0] op_reg   = 7'b0110011; // R format arithmetic

    localparam logic [2:0] arith_f3_add  = 3'b000; // Bit 30 selects sub on op_reg
    localparam logic [2:0] arith_f3_sll  = 3'b001;
    localparam logic [2:0] arith_f3_slt  = 3'b010;
    localparam logic [2:0] arith_f3_sltu = 3'b011;
    localparam logic [2:0] arith_f3_xor  = 3'b100;
    localparam logic [2:0] arith_f3_sr   = 3'b101; // Bit 30 selects arithmetic shift
    localparam logic [2:0] arith_f3_or   = 3'b110;
    localparam logic [2:0] arith_f3_and  = 3'b111;

    localparam logic [2:0] branch_f3_beq  = 3'b000;
    localparam logic [2:0] branch_f3_bne  = 3'b001;
    localparam logic [2:0] branch_f3_blt  = 3'b100;
    localparam logic [2:0] branch_f3_bge  = 3'b101;
    localparam logic [2:0] branch_f3_bltu = 3'b110;
    localparam logic [2:0] branch_f3_bgeu = 3'b111;

    ////////////////////////////////////////
    // Instruction word, one view per format
    ////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_t;

endpackage : rv32i_isa_pkg

`default_nettype wire

// File: logic/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    localparam logic alu_src_rs1 = 1'b0; // First ALU operand
    localparam logic alu_src_pc  = 1'b1;
    localparam logic alu_src_rs2 = 1'b0; // Second ALU operand
    localparam logic alu_src_imm = 1'b1;

    localparam logic [1:0] alu_op_add = 2'b00;
    localparam logic [1:0] alu_op_xor = 2'b01;
    localparam logic [1:0] alu_op_or  = 2'b10;
    localparam logic [1:0] alu_op_and = 2'b11;

    localparam logic shift_left  = 1'b0;
    localparam logic shift_right = 1'b1;

    localparam logic cmp_src_rs2 = 1'b0;
    localparam logic cmp_src_imm = 1'b1;

    localparam logic [2:0] rd_src_alu    = 3'b000;
    localparam logic [2:0] rd_src_shift  = 3'b001;
    localparam logic [2:0] rd_src_cmp    = 3'b010;
    localparam logic [2:0] rd_src_imm    = 3'b011;
    localparam logic [2:0] rd_src_pc_p_4 = 3'b100;

    localparam logic [31:0] reset_pc = 32'h0000_0000; // First fetch address

endpackage : core_ctrl_pkg

`default_nettype wire

// File: logic/decode_if.sv
`timescale 1ns/1ns
`default_nettype none

interface decode_if
    import rv32i_isa_pkg::*;
    import core_ctrl_pkg::*;
();

    logic [reg_addr_width-1:0]  rs1_addr;
    logic [reg_addr_width-1:0]  rs2_addr;
    logic [reg_addr_width-1:0]  rd_addr;
    logic                       rd_write;

    logic                       alu_src_1;
    logic                       alu_src_2;
    logic                       alu_inv_rs2;
    logic                       alu_cin;
    logic [$bits(alu_op_add)-1:0] alu_op;
    logic                       shift_dir;
    logic                       shift_fill; // Bit entering on a right shift
    logic                       cmp_src;
    logic                       cmp_out;
    logic [$bits(rd_src_alu)-1:0] rd_src;
    logic [xlen-1:0]            imm;
    logic                       pc_take_alu;

    // Flags returned by the datapath
    logic                       cmp_lt;   // Unsigned less than
    logic                       cmp_eq;
    logic                       cmp_a_31;
    logic                       cmp_b_31;
    logic                       rs1_31;

    modport decoder (
        output rs1_addr, rs2_addr, rd_addr, rd_write,
        output alu_src_1, alu_src_2, alu_inv_rs2, alu_cin, alu_op,
        output shift_dir, shift_fill, cmp_src, cmp_out, rd_src, imm, pc_take_alu,
        input  cmp_lt, cmp_eq, cmp_a_31, cmp_b_31, rs1_31
    );

    modport exec (
        input  alu_src_1, alu_src_2, alu_inv_rs2, alu_cin, alu_op,
        input  shift_dir, shift_fill, cmp_src, cmp_out, rd_src, imm,
        output cmp_lt, cmp_eq, cmp_a_31, cmp_b_31, rs1_31
    );

    modport regs (input rs1_addr, rs2_addr, rd_addr, rd_write);

    modport pc (input pc_take_alu);

endinterface : decode_if

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder
    import rv32i_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic            reset,
    input  instr_t          instr,
    decode_if.decoder       dec
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            f7_30;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;
    logic [xlen-1:0] j_imm;
    logic            signed_lt;
    logic            is_reg;
    logic            has_rd;
    logic            use_rs1;
    logic            use_rs2;

    ////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////

    always_comb begin
        opcode    = instr.r_fmt.opcode;
        funct3    = instr.r_fmt.funct3;
        f7_30     = instr.r_fmt.funct7[5];
        i_imm     = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
        b_imm     = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                     instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
        u_imm     = {instr.u_fmt.imm_31_12, 12'h000};
        j_imm     = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                     instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
        signed_lt = dec.cmp_lt ^ dec.cmp_a_31 ^ dec.cmp_b_31; // Unsigned result corrected by signs
        is_reg    = (opcode == op_reg);
    end

    ////////////////////////////////////////
    // Control selects
    ////////////////////////////////////////

    always_comb begin
        has_rd          = 1'b0;
        use_rs1         = 1'b0;
        use_rs2         = 1'b0;
        dec.alu_src_1   = alu_src_rs1;
        dec.alu_src_2   = alu_src_imm;
        dec.alu_inv_rs2 = 1'b0;
        dec.alu_cin     = 1'b0;
        dec.alu_op      = alu_op_add;
        dec.shift_dir   = shift_left;
        dec.shift_fill  = 1'b0;
        dec.cmp_src     = cmp_src_rs2;
        dec.cmp_out     = 1'b0;
        dec.rd_src      = rd_src_alu;
        dec.imm         = i_imm;
        dec.pc_take_alu = 1'b0;

        unique case (opcode)
            op_lui: begin
                has_rd     = 1'b1;
                dec.rd_src = rd_src_imm;
                dec.imm    = u_imm;
            end
            op_auipc: begin
                has_rd        = 1'b1;
                dec.alu_src_1 = alu_src_pc;
                dec.imm       = u_imm;
            end
            op_jal: begin
                has_rd          = 1'b1;
                dec.alu_src_1   = alu_src_pc;
                dec.imm         = j_imm;
                dec.rd_src      = rd_src_pc_p_4;
                dec.pc_take_alu = 1'b1;
            end
            op_jalr: begin
                has_rd          = 1'b1;
                use_rs1         = 1'b1;
                dec.rd_src      = rd_src_pc_p_4;
                dec.pc_take_alu = 1'b1;
            end
            op_br: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec.alu_src_1 = alu_src_pc; // Target is PC plus B immediate
                dec.imm       = b_imm;
                unique case (funct3)
                    branch_f3_beq:  dec.cmp_out = dec.cmp_eq;
                    branch_f3_bne:  dec.cmp_out = ~dec.cmp_eq;
                    branch_f3_blt:  dec.cmp_out = signed_lt;
                    branch_f3_bge:  dec.cmp_out = ~signed_lt;
                    branch_f3_bltu: dec.cmp_out = dec.cmp_lt;
                    branch_f3_bgeu: dec.cmp_out = ~dec.cmp_lt;
                    default:        dec.cmp_out = 1'b0;
                endcase
                dec.pc_take_alu = dec.cmp_out;
            end
            op_imm, op_reg: begin
                has_rd        = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = is_reg;
                dec.alu_src_2 = is_reg ? alu_src_rs2 : alu_src_imm;
                dec.cmp_src   = is_reg ? cmp_src_rs2 : cmp_src_imm;
                unique case (funct3)
                    arith_f3_add: begin
                        dec.alu_inv_rs2 = is_reg & f7_30; // Sub as add of inverted rs2 plus one
                        dec.alu_cin     = is_reg & f7_30;
                    end
                    arith_f3_sll:  dec.rd_src = rd_src_shift;
                    arith_f3_slt: begin
                        dec.cmp_out = signed_lt;
                        dec.rd_src  = rd_src_cmp;
                    end
                    arith_f3_sltu: begin
                        dec.cmp_out = dec.cmp_lt;
                        dec.rd_src  = rd_src_cmp;
                    end
                    arith_f3_xor:  dec.alu_op = alu_op_xor;
                    arith_f3_sr: begin
                        dec.shift_dir  = shift_right;
                        dec.shift_fill = f7_30 & dec.rs1_31; // Sign fill for sra
                        dec.rd_src     = rd_src_shift;
                    end
                    arith_f3_or:   dec.alu_op = alu_op_or;
                    arith_f3_and:  dec.alu_op = alu_op_and;
                endcase
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        dec.rs1_addr = use_rs1 ? instr.r_fmt.rs1 : '0;
        dec.rs2_addr = use_rs2 ? instr.r_fmt.rs2 : '0;
        dec.rd_addr  = instr.r_fmt.rd;
        dec.rd_write = has_rd && (instr.r_fmt.rd != '0) && !reset; // No retirement under reset
    end

endmodule : instr_decoder

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv32i_isa_pkg::*;
(
    input  logic            clk,
    decode_if.regs          dec,
    input  logic [xlen-1:0] rd_data,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] reg_mem [2**reg_addr_width];

    always_ff @(posedge clk) begin
        if (dec.rd_write) begin
            reg_mem[dec.rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired to zero
    always_comb begin
        rs1_data = (dec.rs1_addr == '0) ? '0 : reg_mem[dec.rs1_addr];
        rs2_data = (dec.rs2_addr == '0) ? '0 : reg_mem[dec.rs2_addr];
    end

endmodule : reg_file

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit
    import rv32i_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    decode_if.exec          dec,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] pc_p_4,
    output logic [xlen-1:0] alu_result,
    output logic [xlen-1:0] rd_data
);

    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
    logic [xlen-1:0]   op_b_add;
    logic [4:0]        shamt;
    logic [2*xlen-1:0] shift_ext;
    logic [xlen-1:0]   shift_result;
    logic [xlen-1:0]   cmp_b;

    ////////////////////////////////////////
    // ALU and shifter
    ////////////////////////////////////////

    always_comb begin
        op_a     = (dec.alu_src_1 == alu_src_pc) ? pc : rs1_data;
        op_b     = (dec.alu_src_2 == alu_src_imm) ? dec.imm : rs2_data;
        op_b_add = dec.alu_inv_rs2 ? ~op_b : op_b;

        unique case (dec.alu_op)
            alu_op_add: alu_result = op_a + op_b_add + {{(xlen-1){1'b0}}, dec.alu_cin};
            alu_op_xor: alu_result = op_a ^ op_b;
            alu_op_or:  alu_result = op_a | op_b;
            alu_op_and: alu_result = op_a & op_b;
        endcase

        shamt     = op_b[4:0];
        shift_ext = {{xlen{dec.shift_fill}}, op_a} >> shamt; // Upper half supplies the fill
        if (dec.shift_dir == shift_left) begin
            shift_result = op_a << shamt;
        end else begin
            shift_result = shift_ext[xlen-1:0];
        end
    end

    ////////////////////////////////////////
    // Comparator
    ////////////////////////////////////////

    always_comb begin
        cmp_b        = (dec.cmp_src == cmp_src_imm) ? dec.imm : rs2_data;
        dec.cmp_lt   = rs1_data < cmp_b;
        dec.cmp_eq   = rs1_data == cmp_b;
        dec.cmp_a_31 = rs1_data[xlen-1];
        dec.cmp_b_31 = cmp_b[xlen-1];
        dec.rs1_31   = rs1_data[xlen-1];
    end

    always_comb begin
        unique case (dec.rd_src)
            rd_src_shift:  rd_data = shift_result;
            rd_src_cmp:    rd_data = {{(xlen-1){1'b0}}, dec.cmp_out};
            rd_src_imm:    rd_data = dec.imm;
            rd_src_pc_p_4: rd_data = pc_p_4; // Link address
            default:       rd_data = alu_result;
        endcase
    end

endmodule : exec_unit

`default_nettype wire

// File: logic/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

module pc_unit
    import core_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    decode_if.pc        dec,
    input  logic [31:0] alu_result,
    output logic [31:0] pc,
    output logic [31:0] pc_p_4
);

    assign pc_p_4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (dec.pc_take_alu) begin
            pc <= {alu_result[31:1], 1'b0}; // Jump or taken branch
        end else begin
            pc <= pc_p_4;
        end
    end

endmodule : pc_unit

`default_nettype wire

// File: logic/rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core
    import rv32i_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    output logic [xlen-1:0]           imem_addr,
    input  logic [xlen-1:0]           imem_rdata,
    output logic                      rd_write,
    output logic [reg_addr_width-1:0] rd_addr,
    output logic [xlen-1:0]           rd_data
);

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_p_4;

    decode_if dec ();

    instr_decoder u_decoder (
        .reset      (reset),
        .instr      (imem_rdata),
        .dec        (dec.decoder)
    );

    reg_file u_regs (
        .clk        (clk),
        .dec        (dec.regs),
        .rd_data    (rd_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    exec_unit u_exec (
        .dec        (dec.exec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (imem_addr),
        .pc_p_4     (pc_p_4),
        .alu_result (alu_result),
        .rd_data    (rd_data)
    );

    pc_unit u_pc (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec.pc),
        .alu_result (alu_result),
        .pc         (imem_addr), // Fetch address is the PC
        .pc_p_4     (pc_p_4)
    );

    // Retirement view of the write-back
    assign rd_write = dec.rd_write;
    assign rd_addr  = dec.rd_addr;

endmodule : rv32i_core

`default_nettype wire

// File: verification/rv32i_core_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module rv32i_core_assertions
    import core_ctrl_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        rd_write,
    input logic [4:0]  rd_addr,
    input logic [31:0] imem_addr
);

    int error_count = 0;

    ////////////////////////////////////////
    // Retirement port rules
    ////////////////////////////////////////

    no_write_in_reset: assert property (@(posedge clk) reset |-> !rd_write)
        else begin
            error_count++;
            $error("rd_write high during reset");
        end

    no_write_to_x0: assert property (@(posedge clk) rd_write |-> rd_addr != 5'd0)
        else begin
            error_count++;
            $error("write-back addressed to x0");
        end

    pc_after_reset: assert property (@(posedge clk) reset |=> imem_addr == reset_pc)
        else begin
            error_count++;
            $error("imem_addr not at reset_pc after reset");
        end

endmodule : rv32i_core_assertions

bind rv32i_core rv32i_core_assertions core_checks (
    .clk       (clk),
    .reset     (reset),
    .rd_write  (rd_write),
    .rd_addr   (rd_addr),
    .imem_addr (imem_addr)
);

`default_nettype wire

// File: verification/tb_rv32i_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv32i_core
    import rv32i_isa_pkg::*;
    import core_ctrl_pkg::*;
();

    localparam int num_instr    = 2000;
    localparam int max_cycles   = num_instr + 100;
    localparam logic [31:0] seed = 32'h0942_0141;

    logic        clk;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        rd_write;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;

    logic [31:0] lcg_state;
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    logic        running;
    int          checked;
    logic        exp_wr;
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    logic [31:0] exp_next;

    rv32i_core DUT (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .rd_write   (rd_write),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic gen_instr(input int idx, output logic [31:0] word);
        logic [31:0] r;
        logic [31:0] f;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        lcg_state = lcg_step(lcg_state);
        r         = lcg_state;
        lcg_state = lcg_step(lcg_state);
        f         = lcg_state;
        rd        = f[11:7];
        rs1       = f[19:15];
        rs2       = f[24:20];
        f3        = f[14:12];
        if (r[6:4] == 3'd0) begin
            rs2 = rs1; // Equal operands for compare edge cases
        end
        if (idx < 31) begin
            word = {r[31:12], idx[4:0] + 5'd1, op_lui}; // Fill x1..x31 first
        end else begin
            case (r[3:0])
                4'd4, 4'd5, 4'd6, 4'd7: begin
                    if (f3 == arith_f3_sll) begin
                        imm = {7'b0, f[24:20]};
                    end else if (f3 == arith_f3_sr) begin
                        imm = {1'b0, f[30], 5'b0, f[24:20]};
                    end else begin
                        imm = f[31:20];
                    end
                    word = {imm, rs1, f3, rd, op_imm};
                end
                4'd8, 4'd9, 4'd10: begin
                    case (r[10:8])
                        3'd0:       f3 = branch_f3_beq;
                        3'd1:       f3 = branch_f3_bne;
                        3'd2, 3'd6: f3 = branch_f3_blt;
                        3'd3:       f3 = branch_f3_bge;
                        3'd4, 3'd7: f3 = branch_f3_bltu;
                        default:    f3 = branch_f3_bgeu;
                    endcase
                    word = {f[31:25], rs2, rs1, f3, f[11:7], op_br};
                end
                4'd11:   word = {f[31:12], rd, op_lui};
                4'd12:   word = {f[31:12], rd, op_auipc};
                4'd13:   word = {f[31:12], rd, op_jal};
                4'd14:   word = {f[31:20], rs1, 3'b000, rd, op_jalr};
                default: begin
                    word = {1'b0, f[30] & (f3 == arith_f3_add || f3 == arith_f3_sr), 5'b0,
                            rs2, rs1, f3, rd, op_reg};
                end
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] predict_retire(
        input  logic [31:0] ins,
        input  logic [31:0] pc,
        output logic        wr,
        output logic [4:0]  rd,
        output logic [31:0] val
    );
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] i_imm;
        logic [31:0] b_imm;
        logic [31:0] u_imm;
        logic [31:0] j_imm;
        logic [31:0] op_b;
        logic [31:0] next_pc;
        logic [4:0]  sh;
        logic        has_rd;
        logic        take;
        rs1v    = model_regs[ins[19:15]];
        rs2v    = model_regs[ins[24:20]];
        i_imm   = {{20{ins[31]}}, ins[31:20]};
        b_imm   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        u_imm   = {ins[31:12], 12'b0};
        j_imm   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        has_rd  = 1'b0;
        take    = 1'b0;
        val     = 32'b0;
        next_pc = pc + 32'd4;
        case (ins[6:0])
            op_lui: begin
                has_rd = 1'b1;
                val    = u_imm;
            end
            op_auipc: begin
                has_rd = 1'b1;
                val    = pc + u_imm;
            end
            op_jal: begin
                has_rd  = 1'b1;
                val     = pc + 32'd4;
                next_pc = (pc + j_imm) & 32'hffff_fffe;
            end
            op_jalr: begin
                has_rd  = 1'b1;
                val     = pc + 32'd4;
                next_pc = (rs1v + i_imm) & 32'hffff_fffe; // Target bit 0 cleared
            end
            op_br: begin
                case (ins[14:12])
                    branch_f3_beq:  take = (rs1v == rs2v);
                    branch_f3_bne:  take = (rs1v != rs2v);
                    branch_f3_blt:  take = ($signed(rs1v) < $signed(rs2v));
                    branch_f3_bge:  take = ($signed(rs1v) >= $signed(rs2v));
                    branch_f3_bltu: take = (rs1v < rs2v);
                    branch_f3_bgeu: take = (rs1v >= rs2v);
                    default:        take = 1'b0;
                endcase
                if (take) begin
                    next_pc = pc + b_imm;
                end
            end
            op_imm, op_reg: begin
                has_rd = 1'b1;
                op_b   = (ins[6:0] == op_reg) ? rs2v : i_imm;
                sh     = op_b[4:0];
                case (ins[14:12])
                    arith_f3_add: begin
                        if (ins[6:0] == op_reg && ins[30]) begin
                            val = rs1v - op_b;
                        end else begin
                            val = rs1v + op_b;
                        end
                    end
                    arith_f3_sll:  val = rs1v << sh;
                    arith_f3_slt:  val = {31'b0, $signed(rs1v) < $signed(op_b)};
                    arith_f3_sltu: val = {31'b0, rs1v < op_b};
                    arith_f3_xor:  val = rs1v ^ op_b;
                    arith_f3_sr: begin
                        if (ins[30]) begin
                            val = $signed(rs1v) >>> sh;
                        end else begin
                            val = rs1v >> sh;
                        end
                    end
                    arith_f3_or:   val = rs1v | op_b;
                    default:       val = rs1v & op_b;
                endcase
            end
            default: begin
            end
        endcase
        rd = ins[11:7];
        wr = has_rd && (ins[11:7] != 5'd0);
        return next_pc;
    endfunction

    task automatic check_equal(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Check on %s failed", what);
        end
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (running) begin
                exp_next = predict_retire(imem_rdata, model_pc, exp_wr, exp_rd, exp_val);
                check_equal(imem_addr, model_pc, "imem_addr");
                check_equal({31'b0, rd_write}, {31'b0, exp_wr}, "rd_write");
                if (exp_wr) begin
                    check_equal({27'b0, rd_addr}, {27'b0, exp_rd}, "rd_addr");
                    check_equal(rd_data, exp_val, "rd_data");
                    model_regs[exp_rd] = exp_val;
                end
                check_equal(DUT.core_checks.error_count, 32'd0, "assertion failures");
                model_pc = exp_next;
                checked++;
            end
        end
    end

    // Driver and run control
    initial begin
        logic [31:0] instr_word;
        int          idx;
        int          cycles;
        reset      = 1'b1;
        imem_rdata = 32'h0000_0093; // addi x1, x0, 0 held back by reset
        running    = 1'b0;
        checked    = 0;
        lcg_state  = seed;
        model_pc   = reset_pc;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'b0;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        gen_instr(0, instr_word);
        imem_rdata <= instr_word;
        running = 1'b1;

        idx    = 1;
        cycles = 0;
        while (checked < num_instr) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("Timeout: only %0d of %0d instructions checked", checked, num_instr);
                $display("Simulation finished: FAIL");
                $fatal(1, "Run did not complete in time");
            end
            gen_instr(idx, instr_word);
            imem_rdata <= instr_word;
            idx++;
        end

        if (DUT.core_checks.error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Bound assertions reported %0d failures", DUT.core_checks.error_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule : tb_rv32i_core

`default_nettype wire

// File: all.f
logic/rv32i_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/decode_if.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/rv32i_core.sv
verification/rv32i_core_assertions.sv
verification/tb_rv32i_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_rv32i_core -f all.f -o sim_tb_rv32i_core
./obj_dir/sim_tb_rv32i_core
